// ==== Bender.yml ====
package:
  name: lsu_wb

sources:
  - include_dirs:
      - hw
    files:
      - hw/riscv_types_pkg.sv
      - hw/wb_pkg.sv
      - hw/store_aligner.sv
      - hw/load_aligner.sv
      - hw/wishbone_controller.sv
      - hw/wb_data_ram.sv
      - hw/lsu_wb_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/lsu_wb_tb.sv

// ==== hw/load_aligner.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_aligner (
    input  logic [1:0]           addr_i,
    input  riscv_types::load_t   op_i,
    input  logic [`LSU_XLEN-1:0] rdata_i,
    output logic [`LSU_XLEN-1:0] aligned_data_o
);

    import riscv_types::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Lane picked by the low address bits
    always_comb begin
        case (addr_i)
            2'd0:    byte_sel = rdata_i[7:0];
            2'd1:    byte_sel = rdata_i[15:8];
            2'd2:    byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
    end

    assign half_sel = addr_i[1] ? rdata_i[31:16] : rdata_i[15:0];  // Bit 0 ignored

    // ======================================================================
    // Extension
    // ======================================================================

    always_comb begin
        case (op_i)
            LB: begin
                aligned_data_o = {{24{byte_sel[7]}}, byte_sel};
            end
            LBU: begin
                aligned_data_o = {24'd0, byte_sel};
            end
            LH: begin
                aligned_data_o = {{16{half_sel[15]}}, half_sel};
            end
            LHU: begin
                aligned_data_o = {16'd0, half_sel};
            end
            LW:      aligned_data_o = rdata_i;
            default: aligned_data_o = rdata_i;  // Raw word for unknown ops
        endcase
    end

endmodule

// ==== hw/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ==========================================================================
// Data path sizing
// ==========================================================================

// One machine word, used for both data and byte addresses
`define LSU_XLEN 32

// Data RAM depth in words, byte addresses at or above 4x this get an error
`define LSU_RAM_WORDS 256

// ==========================================================================
// Build options
// ==========================================================================

// Nonzero builds the debug access mux in the bus stage
`define LSU_DEBUG_PORT 1

`endif

// ==== hw/lsu_wb_top.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_wb_top (
    input  logic                 clk,
    input  logic                 arst_n_i,

    // Core port
    input  logic [`LSU_XLEN-1:0] proc_addr_i,
    input  logic [`LSU_XLEN-1:0] proc_wdata_i,
    input  logic                 proc_write_i,
    input  logic                 proc_read_i,
    input  logic [2:0]           proc_op_i,
    output logic [`LSU_XLEN-1:0] proc_rdata_o,
    output logic                 proc_ack_o,
    output logic                 proc_stall_o,

    // Debug port
    input  logic                 core_halted_i,
    input  logic                 dbg_am_en_i,
    input  logic                 dbg_am_wr_i,
    input  logic [`LSU_XLEN-1:0] dbg_am_ad_i,
    input  logic [`LSU_XLEN-1:0] dbg_am_do_i,
    output logic [`LSU_XLEN-1:0] dbg_am_di_o,
    output logic                 dbg_am_done_o,

    output logic                 bus_err_o
);

    // Single master, single slave Wishbone link
    logic [`LSU_XLEN-1:0]   wb_adr;
    logic [`LSU_XLEN-1:0]   wb_dat_w;
    logic [`LSU_XLEN-1:0]   wb_dat_r;
    logic [`LSU_XLEN/8-1:0] wb_sel;
    logic                   wb_we;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_ack;
    logic                   wb_err;

    assign bus_err_o = wb_err;

    wishbone_controller u_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .proc_addr_i   (proc_addr_i),
        .proc_wdata_i  (proc_wdata_i),
        .proc_write_i  (proc_write_i),
        .proc_read_i   (proc_read_i),
        .proc_op_i     (proc_op_i),
        .proc_rdata_o  (proc_rdata_o),
        .proc_ack_o    (proc_ack_o),
        .proc_stall_o  (proc_stall_o),
        .core_halted_i (core_halted_i),
        .dbg_am_en_i   (dbg_am_en_i),
        .dbg_am_wr_i   (dbg_am_wr_i),
        .dbg_am_ad_i   (dbg_am_ad_i),
        .dbg_am_do_i   (dbg_am_do_i),
        .dbg_am_di_o   (dbg_am_di_o),
        .dbg_am_done_o (dbg_am_done_o),
        .wb_adr_o      (wb_adr),
        .wb_dat_o      (wb_dat_w),
        .wb_sel_o      (wb_sel),
        .wb_we_o       (wb_we),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_dat_i      (wb_dat_r),
        .wb_ack_i      (wb_ack),
        .wb_err_i      (wb_err)
    );

    wb_data_ram u_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err)
    );

endmodule

// ==== hw/riscv_types_pkg.sv ====
package riscv_types;

    // Store sizes, same codes as funct3 of the S-type instructions
    typedef enum logic [2:0] {
        SB = 3'b000,
        SH = 3'b001,
        SW = 3'b010
    } store_t;

    // Load sizes, funct3 of the I-type loads
    // Bit 2 set means zero extension
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_t;

endpackage

// ==== hw/store_aligner.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module store_aligner (
    input  logic [`LSU_XLEN-1:0]   wdata_i,
    input  riscv_types::store_t    store_type_i,
    input  logic [1:0]             addr_i,
    input  logic                   mem_write_i,
    output logic [`LSU_XLEN/8-1:0] wsel_o,
    output logic [`LSU_XLEN-1:0]   aligned_data_o
);

    import riscv_types::*;

    logic [`LSU_XLEN/8-1:0] sel_d;  // Lane selects before write gating

    always_comb begin
        sel_d          = '0;
        aligned_data_o = wdata_i;
        case (store_type_i)
            SB: begin
                // Byte copied into every lane, select picks one
                aligned_data_o = {4{wdata_i[7:0]}};
                sel_d[addr_i]  = 1'b1;
            end
            SH: begin
                aligned_data_o = {2{wdata_i[15:0]}};
                sel_d          = addr_i[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
            end
            SW: begin
                sel_d = '1;
            end
            default: begin
                sel_d = '0;  // Unknown size writes nothing
            end
        endcase
    end

    // Reads never assert byte selects
    assign wsel_o = mem_write_i ? sel_d : '0;

endmodule

// ==== hw/wb_data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module wb_data_ram (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic [`LSU_XLEN-1:0]   wb_adr_i,
    input  logic [`LSU_XLEN-1:0]   wb_dat_i,
    input  logic [`LSU_XLEN/8-1:0] wb_sel_i,
    input  logic                   wb_we_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    output logic [`LSU_XLEN-1:0]   wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o
);

    import wb_pkg::*;

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    wb_slave_state_t      state_q;
    logic                 err_q;     // Latched range check for the response
    logic                 accept;
    logic                 in_range;
    logic [IDX_W-1:0]     word_idx;

    assign accept   = wb_cyc_i & wb_stb_i & (state_q == WB_IDLE);
    assign in_range = wb_adr_i < `LSU_XLEN'(`LSU_RAM_WORDS * 4);
    assign word_idx = wb_adr_i[IDX_W+1:2];

    // ======================================================================
    // Slave FSM, one wait state and never two responses back to back
    // ======================================================================

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= WB_IDLE;
            err_q   <= 1'b0;
        end else if (accept) begin
            state_q <= WB_RESP;
            err_q   <= ~in_range;
        end else begin
            state_q <= WB_IDLE;  // Response lasts one cycle
        end
    end

    assign wb_ack_o = (state_q == WB_RESP) & ~err_q;
    assign wb_err_o = (state_q == WB_RESP) & err_q;

    // Storage and read word
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_dat_o <= in_range ? mem[word_idx] : '0;
            if (wb_we_i && in_range) begin
                for (int i = 0; i < `LSU_XLEN/8; i++) begin
                    if (wb_sel_i[i])
                        mem[word_idx][i*8 +: 8] <= wb_dat_i[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== hw/wb_pkg.sv ====
package wb_pkg;

    // ======================================================================
    // Wishbone slave side
    // ======================================================================

    // Single access slave, one wait state then response
    typedef enum logic {
        WB_IDLE = 1'b0,  // Waiting for a strobe
        WB_RESP = 1'b1   // Ack or err driven this cycle
    } wb_slave_state_t;

endpackage

// ==== hw/wishbone_controller.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module wishbone_controller (
    input  logic                   clk,
    input  logic                   arst_n_i,

    // Core memory stage
    input  logic [`LSU_XLEN-1:0]   proc_addr_i,
    input  logic [`LSU_XLEN-1:0]   proc_wdata_i,
    input  logic                   proc_write_i,
    input  logic                   proc_read_i,
    input  logic [2:0]             proc_op_i,      // funct3 of the load or store
    output logic [`LSU_XLEN-1:0]   proc_rdata_o,
    output logic                   proc_ack_o,
    output logic                   proc_stall_o,

    // Debug access port, full words only
    input  logic                   core_halted_i,
    input  logic                   dbg_am_en_i,
    input  logic                   dbg_am_wr_i,
    input  logic [`LSU_XLEN-1:0]   dbg_am_ad_i,
    input  logic [`LSU_XLEN-1:0]   dbg_am_do_i,
    output logic [`LSU_XLEN-1:0]   dbg_am_di_o,
    output logic                   dbg_am_done_o,

    // Wishbone master
    output logic [`LSU_XLEN-1:0]   wb_adr_o,
    output logic [`LSU_XLEN-1:0]   wb_dat_o,
    output logic [`LSU_XLEN/8-1:0] wb_sel_o,
    output logic                   wb_we_o,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    input  logic [`LSU_XLEN-1:0]   wb_dat_i,
    input  logic                   wb_ack_i,
    input  logic                   wb_err_i
);

    import riscv_types::*;

    // ======================================================================
    // Core request path
    // ======================================================================

    logic                   core_req;
    logic                   core_ack;      // Ack seen by the core
    logic                   core_err;
    logic [`LSU_XLEN/8-1:0] core_sel;
    logic [`LSU_XLEN-1:0]   core_wdata;
    logic [4:0]             rsp_q;         // {addr[1:0], op} of the access on the bus

    assign core_req     = proc_read_i | proc_write_i;
    assign proc_ack_o   = core_ack | core_err;
    assign proc_stall_o = core_req & ~proc_ack_o;  // Held until the response cycle

    store_aligner u_store_aligner (
        .wdata_i        (proc_wdata_i),
        .store_type_i   (store_t'(proc_op_i)),
        .addr_i         (proc_addr_i[1:0]),
        .mem_write_i    (proc_write_i),
        .wsel_o         (core_sel),
        .aligned_data_o (core_wdata)
    );

    // Request is held, so last cycle's sample matches the acked access
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= {proc_addr_i[1:0], proc_op_i};
        end
    end

    load_aligner u_load_aligner (
        .addr_i         (rsp_q[4:3]),
        .op_i           (load_t'(rsp_q[2:0])),
        .rdata_i        (wb_dat_i),
        .aligned_data_o (proc_rdata_o)
    );

    // ======================================================================
    // Bus ownership
    // ======================================================================

    assign dbg_am_di_o = wb_dat_i;  // No alignment for debug reads

    if (`LSU_DEBUG_PORT != 0) begin : g_dbg_mux
        // Debug owns the bus while the core is halted
        assign wb_adr_o = core_halted_i ? dbg_am_ad_i : proc_addr_i;
        assign wb_dat_o = core_halted_i ? dbg_am_do_i : core_wdata;
        assign wb_sel_o = core_halted_i ? '1          : core_sel;
        assign wb_we_o  = core_halted_i ? dbg_am_wr_i : proc_write_i;
        assign wb_cyc_o = core_halted_i ? dbg_am_en_i : core_req;
        assign wb_stb_o = core_halted_i ? dbg_am_en_i : core_req;

        assign core_ack      = ~core_halted_i & wb_ack_i;
        assign core_err      = ~core_halted_i & wb_err_i;
        assign dbg_am_done_o = core_halted_i & (wb_ack_i | wb_err_i);
    end else begin : g_core_only
        assign wb_adr_o = proc_addr_i;
        assign wb_dat_o = core_wdata;
        assign wb_sel_o = core_sel;
        assign wb_we_o  = proc_write_i;
        assign wb_cyc_o = core_req;
        assign wb_stb_o = core_req;

        assign core_ack      = wb_ack_i;
        assign core_err      = wb_err_i;
        assign dbg_am_done_o = 1'b0;
    end

endmodule

// ==== lsu_wb.f ====
+incdir+hw
hw/riscv_types_pkg.sv
hw/wb_pkg.sv
hw/store_aligner.sv
hw/load_aligner.sv
hw/wishbone_controller.sv
hw/wb_data_ram.sv
hw/lsu_wb_top.sv
verification/lsu_wb_tb.sv

// ==== verification/lsu_wb_patterns.txt ====
// port(0 core, 1 debug) dir(1 write) op(funct3) addr wdata exp_rdata exp_err
// All columns hex, op unused on debug lines
// Word store and load
0 1 2 00000010 DEADBEEF 00000000 0
0 0 2 00000010 00000000 DEADBEEF 0
// Byte and halfword lane merges into one word
0 1 2 00000020 00000000 00000000 0
0 1 0 00000020 000000A1 00000000 0
0 1 1 00000022 00005566 00000000 0
0 1 0 00000021 0000FFB2 00000000 0
0 1 0 00000023 0000007C 00000000 0
0 0 2 00000020 00000000 7C66B2A1 0
// Sign and zero extension on every lane
0 1 2 00000030 F07F8001 00000000 0
0 0 0 00000030 00000000 00000001 0
0 0 0 00000031 00000000 FFFFFF80 0
0 0 0 00000032 00000000 0000007F 0
0 0 0 00000033 00000000 FFFFFFF0 0
0 0 4 00000030 00000000 00000001 0
0 0 4 00000031 00000000 00000080 0
0 0 4 00000032 00000000 0000007F 0
0 0 4 00000033 00000000 000000F0 0
0 0 1 00000030 00000000 FFFF8001 0
0 0 1 00000032 00000000 FFFFF07F 0
0 0 5 00000030 00000000 00008001 0
0 0 5 00000032 00000000 0000F07F 0
// Out of range, the aliased word must stay intact
0 1 2 00000410 12345678 00000000 1
0 0 2 00000400 00000000 00000000 1
0 0 2 00000010 00000000 DEADBEEF 0
// Debug port while halted
1 1 0 00000040 11223344 00000000 0
1 0 0 00000040 00000000 11223344 0
1 0 0 00000010 00000000 DEADBEEF 0
0 0 2 00000040 00000000 11223344 0

// ==== verification/lsu_wb_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_wb_tb;

    import riscv_types::*;

    localparam int FIELDS  = 7;   // Columns per access in the pattern file
    localparam int MAX_PAT = 64;

    logic                 clk;
    logic                 arst_n_i;
    logic [`LSU_XLEN-1:0] proc_addr_i;
    logic [`LSU_XLEN-1:0] proc_wdata_i;
    logic                 proc_write_i;
    logic                 proc_read_i;
    logic [2:0]           proc_op_i;
    logic [`LSU_XLEN-1:0] proc_rdata_o;
    logic                 proc_ack_o;
    logic                 proc_stall_o;
    logic                 core_halted_i;
    logic                 dbg_am_en_i;
    logic                 dbg_am_wr_i;
    logic [`LSU_XLEN-1:0] dbg_am_ad_i;
    logic [`LSU_XLEN-1:0] dbg_am_do_i;
    logic [`LSU_XLEN-1:0] dbg_am_di_o;
    logic                 dbg_am_done_o;
    logic                 bus_err_o;

    logic [31:0] pat_mem [FIELDS*MAX_PAT];
    int          num_pat;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          cycle_limit;
    int          cur_pat;

    lsu_wb_top DUT (.*);

    always #2 clk = ~clk;

    // A wb_slave_state_t FSM stuck away from WB_IDLE would stall the core forever
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run went past the limit of %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("error: pattern %0d %s = 0x%08h, expected 0x%08h",
                     cur_pat, name, actual, expected);
            error_count++;
        end
    endtask

    // ========================================================================
    // One access from the pattern file
    // ========================================================================

    task automatic run_access(input int idx);
        logic [31:0] port;
        logic [31:0] dir;
        logic [31:0] exp_rdata;
        logic [31:0] exp_err;
        logic        seen;
        int          waited;
        port      = pat_mem[idx*FIELDS];
        dir       = pat_mem[idx*FIELDS+1];
        exp_rdata = pat_mem[idx*FIELDS+5];
        exp_err   = pat_mem[idx*FIELDS+6];
        cur_pat   = idx;
        proc_addr_i  = pat_mem[idx*FIELDS+3];
        proc_wdata_i = pat_mem[idx*FIELDS+4];
        if (port == 0) begin
            proc_op_i    = pat_mem[idx*FIELDS+2][2:0];
            proc_write_i = dir[0];
            proc_read_i  = ~dir[0];
        end else begin
            core_halted_i = 1'b1;
            dbg_am_en_i   = 1'b1;
            dbg_am_wr_i   = dir[0];
            dbg_am_ad_i   = pat_mem[idx*FIELDS+3];
            dbg_am_do_i   = pat_mem[idx*FIELDS+4];
            proc_op_i     = LW;
            proc_read_i   = 1'b1;  // Core load parked behind the debug access
        end
        #1;
        check_value("proc_stall_o", proc_stall_o, 1);
        check_value("proc_ack_o", proc_ack_o, 0);
        check_value("dbg_am_done_o", dbg_am_done_o, 0);
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < 4) begin
            @(negedge clk);
            waited++;
            seen = (port == 0) ? proc_ack_o : dbg_am_done_o;
        end
        if (!seen) begin
            $display("Pattern %0d got no acknowledge within 4 cycles", idx);
            error_count++;
        end else begin
            check_value("bus_err_o", bus_err_o, exp_err);
            if (port == 0) begin
                check_value("proc_stall_o", proc_stall_o, 0);
                check_value("dbg_am_done_o", dbg_am_done_o, 0);  // Only set while halted
                if (!dir[0])
                    check_value("proc_rdata_o", proc_rdata_o, exp_rdata);
            end else begin
                if (!dir[0])
                    check_value("dbg_am_di_o", dbg_am_di_o, exp_rdata);
                check_value("proc_ack_o", proc_ack_o, 0);  // Halted core never acked
                check_value("proc_stall_o", proc_stall_o, 1);
            end
        end
        // Halt stays up one more cycle so a second done would show
        proc_write_i  = 1'b0;
        proc_read_i   = 1'b0;
        dbg_am_en_i   = 1'b0;
        @(negedge clk);
        check_value("proc_stall_o", proc_stall_o, 0);
        check_value("proc_ack_o", proc_ack_o, 0);
        check_value("dbg_am_done_o", dbg_am_done_o, 0);
        core_halted_i = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
    endtask

    initial begin
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        proc_addr_i   = '0;
        proc_wdata_i  = '0;
        proc_write_i  = 1'b0;
        proc_read_i   = 1'b0;
        proc_op_i     = LW;
        core_halted_i = 1'b0;
        dbg_am_en_i   = 1'b0;
        dbg_am_wr_i   = 1'b0;
        dbg_am_ad_i   = '0;
        dbg_am_do_i   = '0;
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        num_pat       = 0;
        cur_pat       = 0;
        void'($urandom(55019));

        $readmemh("verification/lsu_wb_patterns.txt", pat_mem);
        while (num_pat < MAX_PAT && !$isunknown(pat_mem[num_pat*FIELDS]))
            num_pat++;
        cycle_limit = 3 + 6 * num_pat + 20;
        if (num_pat == 0) begin
            $display("The pattern file held no accesses");
            error_count++;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);

        for (int i = 0; i < num_pat; i++)
            run_access(i);

        $display("Errors: %0d in %0d checks over %0d accesses",
                 error_count, check_count, num_pat);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
